//--- common/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Width of a register and of one memory word.
    localparam int unsigned XLEN = 64;

    localparam int unsigned DWORD_BYTES = XLEN / 8;
    localparam int unsigned DWORD_OFFSET_BITS = $clog2(DWORD_BYTES);

    localparam int unsigned WORD_BITS = XLEN / 2;
    localparam int unsigned HALF_BITS = XLEN / 4;

    // One doubleword read back from memory, decoded as a whole, as words,
    // as halfwords or as bytes. Element 0 is always the lowest address.
    typedef union packed {
        logic [XLEN-1:0]                  d;
        logic [1:0][WORD_BITS-1:0]        w;
        logic [3:0][HALF_BITS-1:0]        h;
        logic [DWORD_BYTES-1:0][7:0]      b;
    } dword_view_t;

endpackage

`default_nettype wire

//--- common/load_pkg.sv
`default_nettype none

package load_pkg;

    // Base ISA instructions only, so a fetch is always one 32-bit word.
    localparam int unsigned INSTR_WIDTH = 32;

    localparam int unsigned LOAD_OP_WIDTH = 3;

    // Load funct3 codes. Bit 2 set means the field is zero-extended.
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LB  = 3'b000;
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LH  = 3'b001;
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LW  = 3'b010;
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LD  = 3'b011;
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LBU = 3'b100;
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LHU = 3'b101;
    localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LWU = 3'b110;

    // 3'b111 would be LDU, which RV64 does not define.

endpackage

`default_nettype wire

//--- source/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram
    import mem_pkg::*;
#(
    parameter int unsigned     DEPTH_LOG2 = 10,
    parameter logic [XLEN-1:0] BASE_ADDR  = 64'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  logic [XLEN-1:0] wr_addr,
    input  logic [XLEN-1:0] wr_data,
    input  logic            rd_a_en,
    input  logic [XLEN-1:0] rd_a_addr,
    output logic [XLEN-1:0] rd_a_data,
    output logic            rd_a_error,
    input  logic            rd_b_en,
    input  logic [XLEN-1:0] rd_b_addr,
    output logic [XLEN-1:0] rd_b_data,
    output logic            rd_b_error
);

    localparam int unsigned DEPTH = 2 ** DEPTH_LOG2;
    localparam int unsigned WINDOW_LSB = DWORD_OFFSET_BITS + DEPTH_LOG2;

    logic [XLEN-1:0] mem [DEPTH];

    // BASE_ADDR is aligned to the memory size, so only the bits above the
    // index have to match.
    function automatic logic in_window(input logic [XLEN-1:0] addr);
        return addr[XLEN-1:WINDOW_LSB] == BASE_ADDR[XLEN-1:WINDOW_LSB];
    endfunction

    function automatic logic [DEPTH_LOG2-1:0] word_index(input logic [XLEN-1:0] addr);
        return addr[DWORD_OFFSET_BITS +: DEPTH_LOG2];
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en && in_window(wr_addr)) begin
            mem[word_index(wr_addr)] <= wr_data; // Outside the window is dropped.
        end
    end

    // Both read ports sample the array before this edge's write lands.
    always_ff @(posedge clk) begin
        if (rd_a_en) begin
            rd_a_data <= mem[word_index(rd_a_addr)];
        end
        if (rd_b_en) begin
            rd_b_data <= mem[word_index(rd_b_addr)];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_a_error <= 1'b0;
            rd_b_error <= 1'b0;
        end else begin
            if (rd_a_en) begin
                rd_a_error <= !in_window(rd_a_addr);
            end
            if (rd_b_en) begin
                rd_b_error <= !in_window(rd_b_addr);
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
    import mem_pkg::*;
    import load_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_req,
    input  logic [XLEN-1:0]        pc,
    output logic                   rd_en,
    output logic [XLEN-1:0]        rd_addr,
    input  logic [XLEN-1:0]        rd_data,
    input  logic                   rd_error,
    output logic [INSTR_WIDTH-1:0] instr,
    output logic                   fetch_valid,
    output logic                   fetch_error
);

    logic        pc_upper;
    logic        pc_misaligned;
    dword_view_t fetch_view;

    // The RAM port carries the request itself. Only the result needs state.
    assign rd_en   = fetch_req;
    assign rd_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid   <= 1'b0;
            pc_upper      <= 1'b0;
            pc_misaligned <= 1'b0;
        end else begin
            fetch_valid <= fetch_req;
            if (fetch_req) begin
                pc_upper      <= pc[2];
                pc_misaligned <= |pc[1:0];
            end
        end
    end

    assign fetch_view.d = rd_data;

    assign fetch_error = fetch_valid && (rd_error || pc_misaligned);

    // Little endian, so pc bit 2 picks the upper word.
    assign instr = fetch_error ? '0 : fetch_view.w[pc_upper];

endmodule

`default_nettype wire

//--- load/data_load.sv
`timescale 1ns/1ps
`default_nettype none

module data_load
    import mem_pkg::*;
    import load_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_req,
    input  logic [XLEN-1:0]          load_addr,
    input  logic [LOAD_OP_WIDTH-1:0] load_op,
    output logic                     rd_en,
    output logic [XLEN-1:0]          rd_addr,
    input  logic [XLEN-1:0]          rd_data,
    input  logic                     rd_error,
    output logic [XLEN-1:0]          load_data,
    output logic                     load_valid,
    output logic                     load_error
);

    logic [DWORD_OFFSET_BITS-1:0] addr_low;
    logic [LOAD_OP_WIDTH-1:0]     op_q;
    dword_view_t                  load_view;
    logic [7:0]                   byte_field;
    logic [HALF_BITS-1:0]         half_field;
    logic [WORD_BITS-1:0]         word_field;
    logic [XLEN-1:0]              ext_data;
    logic                         misaligned;
    logic                         op_undefined;

    assign rd_en   = load_req;
    assign rd_addr = load_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_valid <= 1'b0;
            addr_low   <= '0;
            op_q       <= '0;
        end else begin
            load_valid <= load_req;
            if (load_req) begin
                addr_low <= load_addr[DWORD_OFFSET_BITS-1:0];
                op_q     <= load_op;
            end
        end
    end

    assign load_view.d = rd_data;

    // Halves and words sit on their natural boundary, so the low offset
    // bits below the field size are dropped here and checked below.
    assign byte_field = load_view.b[addr_low];
    assign half_field = load_view.h[addr_low[2:1]];
    assign word_field = load_view.w[addr_low[2]];

    always_comb begin
        ext_data     = '0;
        misaligned   = 1'b0;
        op_undefined = 1'b0;
        case (op_q)
            LOAD_LB:  ext_data = {{(XLEN-8){byte_field[7]}}, byte_field};
            LOAD_LBU: ext_data = {{(XLEN-8){1'b0}}, byte_field};
            LOAD_LH: begin
                ext_data   = {{(XLEN-HALF_BITS){half_field[HALF_BITS-1]}}, half_field};
                misaligned = addr_low[0];
            end
            LOAD_LHU: begin
                ext_data   = {{(XLEN-HALF_BITS){1'b0}}, half_field};
                misaligned = addr_low[0];
            end
            LOAD_LW: begin
                ext_data   = {{(XLEN-WORD_BITS){word_field[WORD_BITS-1]}}, word_field};
                misaligned = |addr_low[1:0];
            end
            LOAD_LWU: begin
                ext_data   = {{(XLEN-WORD_BITS){1'b0}}, word_field};
                misaligned = |addr_low[1:0];
            end
            LOAD_LD: begin
                ext_data   = load_view.d;
                misaligned = |addr_low;
            end
            default: op_undefined = 1'b1;
        endcase
    end

    assign load_error = load_valid && (rd_error || misaligned || op_undefined);
    assign load_data  = load_error ? '0 : ext_data;

endmodule

`default_nettype wire

//--- source/mem_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_read_top
    import mem_pkg::*;
    import load_pkg::*;
#(
    parameter int unsigned     DEPTH_LOG2 = 10,
    parameter logic [XLEN-1:0] BASE_ADDR  = 64'h8000_0000
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic [XLEN-1:0]          wr_addr,
    input  logic [XLEN-1:0]          wr_data,
    input  logic                     fetch_req,
    input  logic [XLEN-1:0]          pc,
    output logic [INSTR_WIDTH-1:0]   instr,
    output logic                     fetch_valid,
    output logic                     fetch_error,
    input  logic                     load_req,
    input  logic [XLEN-1:0]          load_addr,
    input  logic [LOAD_OP_WIDTH-1:0] load_op,
    output logic [XLEN-1:0]          load_data,
    output logic                     load_valid,
    output logic                     load_error
);

    logic            rd_a_en;
    logic [XLEN-1:0] rd_a_addr;
    logic [XLEN-1:0] rd_a_data;
    logic            rd_a_error;
    logic            rd_b_en;
    logic [XLEN-1:0] rd_b_addr;
    logic [XLEN-1:0] rd_b_data;
    logic            rd_b_error;

    // Port A serves instruction fetch and port B serves data loads.
    word_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .BASE_ADDR  (BASE_ADDR)
    ) word_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_a_en    (rd_a_en),
        .rd_a_addr  (rd_a_addr),
        .rd_a_data  (rd_a_data),
        .rd_a_error (rd_a_error),
        .rd_b_en    (rd_b_en),
        .rd_b_addr  (rd_b_addr),
        .rd_b_data  (rd_b_data),
        .rd_b_error (rd_b_error)
    );

    instr_fetch instr_fetch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .rd_en       (rd_a_en),
        .rd_addr     (rd_a_addr),
        .rd_data     (rd_a_data),
        .rd_error    (rd_a_error),
        .instr       (instr),
        .fetch_valid (fetch_valid),
        .fetch_error (fetch_error)
    );

    data_load data_load_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_req   (load_req),
        .load_addr  (load_addr),
        .load_op    (load_op),
        .rd_en      (rd_b_en),
        .rd_addr    (rd_b_addr),
        .rd_data    (rd_b_data),
        .rd_error   (rd_b_error),
        .load_data  (load_data),
        .load_valid (load_valid),
        .load_error (load_error)
    );

endmodule

`default_nettype wire

//--- test/mem_read_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_read_props (
    input logic clk,
    input logic rst_n,
    input logic fetch_req,
    input logic fetch_valid,
    input logic fetch_error,
    input logic load_req,
    input logic load_valid,
    input logic load_error
);

    // Each port answers every request exactly one cycle later.
    fetch_valid_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_valid == $past(fetch_req)
    ) else $error("fetch_valid does not follow fetch_req by one cycle");

    load_valid_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n) load_valid == $past(load_req)
    ) else $error("load_valid does not follow load_req by one cycle");

    fetch_error_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_error |-> fetch_valid
    ) else $error("fetch_error is high without fetch_valid");

    load_error_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) load_error |-> load_valid
    ) else $error("load_error is high without load_valid");

    valids_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> (!fetch_valid && !load_valid)
    ) else $error("a valid strobe is high while reset is asserted");

endmodule

bind mem_read_top mem_read_props mem_read_props_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_valid (fetch_valid),
    .fetch_error (fetch_error),
    .load_req    (load_req),
    .load_valid  (load_valid),
    .load_error  (load_error)
);

`default_nettype wire

//--- test/mem_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_read_tb
    import mem_pkg::*;
    import load_pkg::*;
();

    localparam int unsigned     DEPTH_LOG2 = 10;
    localparam logic [XLEN-1:0] BASE_ADDR  = 64'h8000_0000;
    localparam int unsigned     MEM_BYTES  = DWORD_BYTES << DEPTH_LOG2;

    localparam int CLK_PERIOD         = 4;
    localparam int RESET_CYCLES       = 8;
    localparam int PRELOAD_DWORDS     = 64;
    localparam int LOAD_DWORDS        = 4;
    localparam int LOADS_PER_DWORD    = 29;
    localparam int ERROR_REQUESTS     = 26;
    localparam int SAME_EDGE_REQUESTS = 4;
    localparam int TOTAL_REQUESTS     = 2 * PRELOAD_DWORDS + LOAD_DWORDS * LOADS_PER_DWORD
                                        + ERROR_REQUESTS + SAME_EDGE_REQUESTS;
    localparam int WATCHDOG_NS = (RESET_CYCLES + PRELOAD_DWORDS + TOTAL_REQUESTS)
                                 * CLK_PERIOD * 4;

    logic                     clk;
    logic                     rst_n;
    logic                     wr_en;
    logic [XLEN-1:0]          wr_addr;
    logic [XLEN-1:0]          wr_data;
    logic                     fetch_req;
    logic [XLEN-1:0]          pc;
    logic [INSTR_WIDTH-1:0]   instr;
    logic                     fetch_valid;
    logic                     fetch_error;
    logic                     load_req;
    logic [XLEN-1:0]          load_addr;
    logic [LOAD_OP_WIDTH-1:0] load_op;
    logic [XLEN-1:0]          load_data;
    logic                     load_valid;
    logic                     load_error;

    dword_view_t model [PRELOAD_DWORDS]; // Mirror of the preloaded area.

    // Pending requests with their expected results, issued back to back.
    logic [XLEN-1:0]          fetch_pc_q  [$];
    logic [INSTR_WIDTH-1:0]   fetch_exp_q [$];
    logic                     fetch_err_q [$];
    logic [XLEN-1:0]          load_addr_q [$];
    logic [LOAD_OP_WIDTH-1:0] load_op_q   [$];
    logic [XLEN-1:0]          load_exp_q  [$];
    logic                     load_err_q  [$];

    int test_errors;
    int tests_passed;
    int tests_failed;

    mem_read_top #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .BASE_ADDR  (BASE_ADDR)
    ) mem_read_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .instr       (instr),
        .fetch_valid (fetch_valid),
        .fetch_error (fetch_error),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .load_op     (load_op),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .load_error  (load_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [XLEN-1:0] dword_addr(input int index);
        return BASE_ADDR + index * DWORD_BYTES;
    endfunction

    function automatic int field_bytes(input logic [LOAD_OP_WIDTH-1:0] op);
        case (op)
            LOAD_LB, LOAD_LBU: return 1;
            LOAD_LH, LOAD_LHU: return 2;
            LOAD_LW, LOAD_LWU: return 4;
            default:           return 8;
        endcase
    endfunction

    // Field at the byte offset, widened to 64 bits as the RISC-V load rules say.
    function automatic logic [XLEN-1:0] expected_load(input dword_view_t v, input int offset,
                                                     input logic [LOAD_OP_WIDTH-1:0] op);
        logic [XLEN-1:0] field;
        logic            is_unsigned;
        int              bytes;
        bytes       = field_bytes(op);
        is_unsigned = (op == LOAD_LBU) || (op == LOAD_LHU) || (op == LOAD_LWU);
        case (bytes)
            1:       field = v.b[offset];
            2:       field = v.h[offset / 2];
            4:       field = v.w[offset / 4];
            default: field = v.d;
        endcase
        if (bytes < DWORD_BYTES && !is_unsigned && field[bytes * 8 - 1]) begin
            field = field | ({XLEN{1'b1}} << (bytes * 8));
        end
        return field;
    endfunction

    task automatic check_dword(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_instr(input string name, input logic [INSTR_WIDTH-1:0] expected,
                               input logic [INSTR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_fetch_result(input string name, input logic [INSTR_WIDTH-1:0] exp_instr,
                                      input logic exp_error);
        if (fetch_valid !== 1'b1) begin
            $display("%s: fetch_valid did not rise one cycle after the request", name);
            test_errors++;
        end else begin
            check_instr(name, exp_instr, instr);
            check_flag({name, " error"}, exp_error, fetch_error);
        end
    endtask

    task automatic check_load_result(input string name, input logic [XLEN-1:0] exp_data,
                                     input logic exp_error);
        if (load_valid !== 1'b1) begin
            $display("%s: load_valid did not rise one cycle after the request", name);
            test_errors++;
        end else begin
            check_dword(name, exp_data, load_data);
            check_flag({name, " error"}, exp_error, load_error);
        end
    endtask

    task automatic check_no_result(input string name, input string port, input logic valid);
        if (valid !== 1'b0) begin
            $display("%s: %s valid is high with no request one cycle earlier", name, port);
            test_errors++;
        end
    endtask

    task automatic push_fetch(input logic [XLEN-1:0] addr, input logic [INSTR_WIDTH-1:0] exp,
                              input logic err);
        fetch_pc_q.push_back(addr);
        fetch_exp_q.push_back(exp);
        fetch_err_q.push_back(err);
    endtask

    task automatic push_load(input logic [XLEN-1:0] addr, input logic [LOAD_OP_WIDTH-1:0] op,
                             input logic [XLEN-1:0] exp, input logic err);
        load_addr_q.push_back(addr);
        load_op_q.push_back(op);
        load_exp_q.push_back(exp);
        load_err_q.push_back(err);
    endtask

    // Both queues run side by side, one request per cycle on each port.
    task automatic run_requests(input string name);
        int n_fetch;
        int n_load;
        int n;
        n_fetch = fetch_pc_q.size();
        n_load  = load_addr_q.size();
        n       = (n_fetch > n_load) ? n_fetch : n_load;
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            fetch_req <= (i < n_fetch);
            load_req  <= (i < n_load);
            if (i < n_fetch) begin
                pc <= fetch_pc_q[i];
            end
            if (i < n_load) begin
                load_addr <= load_addr_q[i];
                load_op   <= load_op_q[i];
            end
            @(negedge clk);
            if (i >= 1 && i <= n_fetch) begin
                check_fetch_result($sformatf("%s fetch %0d", name, i - 1),
                                   fetch_exp_q[i - 1], fetch_err_q[i - 1]);
            end else begin
                check_no_result(name, "fetch", fetch_valid);
            end
            if (i >= 1 && i <= n_load) begin
                check_load_result($sformatf("%s load %0d", name, i - 1),
                                  load_exp_q[i - 1], load_err_q[i - 1]);
            end else begin
                check_no_result(name, "load", load_valid);
            end
        end
        fetch_pc_q.delete();
        fetch_exp_q.delete();
        fetch_err_q.delete();
        load_addr_q.delete();
        load_op_q.delete();
        load_exp_q.delete();
        load_err_q.delete();
    endtask

    task automatic finish_test(input string name);
        $display("%-12s done with %0d errors", name, test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic preload_memory();
        for (int i = 0; i < PRELOAD_DWORDS; i++) begin
            model[i].d = {$urandom, $urandom};
            if (i % 4 == 1) begin
                model[i].d = model[i].d | 64'h8080_8080_8080_8080; // Every field negative.
            end else if (i % 4 == 2) begin
                model[i].d = model[i].d & 64'h7f7f_7f7f_7f7f_7f7f;
            end
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= dword_addr(i);
            wr_data <= model[i].d;
            @(negedge clk);
            check_flag("preload fetch_valid", 1'b0, fetch_valid);
            check_flag("preload load_valid", 1'b0, load_valid);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check_flag("reset_idle fetch_valid", 1'b0, fetch_valid);
        check_flag("reset_idle load_valid", 1'b0, load_valid);
        check_flag("reset_idle fetch_error", 1'b0, fetch_error);
        check_flag("reset_idle load_error", 1'b0, load_error);
        preload_memory();
        finish_test("reset_idle");
    endtask

    task automatic test_fetch_sweep();
        for (int k = 0; k < PRELOAD_DWORDS; k++) begin
            push_fetch(dword_addr(k), model[k].w[0], 1'b0);
            push_fetch(dword_addr(k) + 4, model[k].w[1], 1'b0);
        end
        run_requests("fetch_sweep");
        finish_test("fetch_sweep");
    endtask

    task automatic test_load_fields();
        logic [LOAD_OP_WIDTH-1:0] ops [7];
        int                       picks [LOAD_DWORDS];
        ops = '{LOAD_LB, LOAD_LH, LOAD_LW, LOAD_LD, LOAD_LBU, LOAD_LHU, LOAD_LWU};
        picks[0] = 1;
        picks[1] = 2;
        picks[2] = $urandom_range(PRELOAD_DWORDS - 1);
        picks[3] = $urandom_range(PRELOAD_DWORDS - 1);
        for (int s = 0; s < LOAD_DWORDS; s++) begin
            for (int o = 0; o < 7; o++) begin
                for (int off = 0; off < DWORD_BYTES; off += field_bytes(ops[o])) begin
                    push_load(dword_addr(picks[s]) + off, ops[o],
                              expected_load(model[picks[s]], off, ops[o]), 1'b0);
                end
            end
        end
        run_requests("load_fields");
        finish_test("load_fields");
    endtask

    task automatic test_error_cases();
        push_fetch(BASE_ADDR - 8, '0, 1'b1);
        push_fetch(BASE_ADDR + MEM_BYTES, '0, 1'b1);
        for (int b = 1; b < 4; b++) begin
            push_fetch(dword_addr(3) + b, '0, 1'b1);
        end
        push_load(BASE_ADDR + MEM_BYTES, LOAD_LD, '0, 1'b1);
        push_load(64'h0, LOAD_LB, '0, 1'b1);
        for (int off = 1; off < DWORD_BYTES; off += 2) begin
            push_load(dword_addr(5) + off, LOAD_LH, '0, 1'b1);
        end
        push_load(dword_addr(5) + 3, LOAD_LHU, '0, 1'b1);
        for (int off = 1; off < DWORD_BYTES; off++) begin
            if (off % 4 != 0) begin
                push_load(dword_addr(5) + off, LOAD_LW, '0, 1'b1);
            end
        end
        for (int off = 1; off < DWORD_BYTES; off++) begin
            push_load(dword_addr(5) + off, LOAD_LD, '0, 1'b1);
        end
        push_load(dword_addr(5), 3'b111, '0, 1'b1);
        run_requests("error_cases");
        finish_test("error_cases");
    endtask

    task automatic test_same_edge();
        logic [XLEN-1:0] new_value;
        push_fetch(dword_addr(7) + 4, model[7].w[1], 1'b0);
        push_load(dword_addr(7), LOAD_LD, model[7].d, 1'b0);
        run_requests("same_edge");
        new_value = ~model[7].d;
        @(posedge clk);
        wr_en     <= 1'b1;
        wr_addr   <= dword_addr(7);
        wr_data   <= new_value;
        load_req  <= 1'b1;
        load_addr <= dword_addr(7);
        load_op   <= LOAD_LD;
        @(posedge clk);
        wr_en <= 1'b0;
        @(negedge clk);
        check_load_result("same_edge old data", model[7].d, 1'b0);
        @(posedge clk);
        load_req <= 1'b0;
        @(negedge clk);
        check_load_result("same_edge new data", new_value, 1'b0);
        model[7].d = new_value;
        finish_test("same_edge");
    endtask

    initial begin
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        fetch_req    = 1'b0;
        pc           = '0;
        load_req     = 1'b0;
        load_addr    = '0;
        load_op      = '0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h6e0c0e67));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_idle();
        test_fetch_sweep();
        test_load_fields();
        test_error_cases();
        test_same_edge();
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
common/mem_pkg.sv
common/load_pkg.sv
source/word_ram.sv
fetch/instr_fetch.sv
load/data_load.sv
source/mem_read_top.sv
test/mem_read_props.sv
test/mem_read_tb.sv
